//--- source/box_pkg.sv
package box_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////

  localparam int PX_W         = 8;
  localparam int WIN          = 3;
  localparam int LINE_BUFS    = WIN + 1;                // one line is written while three are read
  localparam int MAX_LINE_LEN = 16;
  localparam int LINE_ADDR_W  = $clog2( MAX_LINE_LEN );
  localparam int BUF_IDX_W    = $clog2( LINE_BUFS );
  localparam int SUM_W        = PX_W + 4;               // nine full scale pixels still fit

  //////////////////////////////
  // stream words
  //////////////////////////////

  typedef logic [PX_W - 1 : 0] px_t;

  typedef struct packed {
    px_t  tdata;
    logic tvalid;
    logic tlast;                                        // last pixel of a line
    logic tuser;                                        // first pixel of a frame
  } stream_word_t;

  // px[row][col], row 0 is the oldest line and col 0 the leftmost column
  typedef struct packed {
    px_t [WIN - 1 : 0][WIN - 1 : 0] px;
    logic                           tvalid;
    logic                           tlast;
    logic                           tuser;
  } window_t;

  typedef struct packed {
    logic [SUM_W - 1 : 0] tdata;
    logic                 tvalid;
    logic                 tlast;
    logic                 tuser;
  } sum_word_t;

endpackage

//--- source/line_buf.sv
`timescale 1ns/1ps

module line_buf
  import box_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     wr_i,
  input  px_t                      wr_px_i,
  input  logic                     wr_last_i,
  input  logic [LINE_ADDR_W - 1 : 0] rd_addr_i,
  input  logic                     flush_i,
  output px_t                      rd_px_o,
  output logic                     full_o,
  output logic [LINE_ADDR_W : 0]   len_o
);

px_t                      mem [MAX_LINE_LEN];
logic [LINE_ADDR_W - 1 : 0] wr_ptr;
logic [LINE_ADDR_W - 1 : 0] base_ptr;

// a flush and the first write of the next line may share one cycle
assign base_ptr = flush_i ? '0 : wr_ptr;

//////////////////////////////
// pixel storage
//////////////////////////////

always_ff @( posedge clk_i )
  if( wr_i )
    mem[base_ptr] <= wr_px_i;

always_ff @( posedge clk_i )
  rd_px_o <= mem[rd_addr_i];                            // one cycle behind the address

//////////////////////////////
// line status
//////////////////////////////

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      wr_ptr <= '0;
      full_o <= 1'b0;
      len_o  <= '0;
    end
  else
    begin
      if( flush_i )
        full_o <= 1'b0;
      if( wr_i )
        begin
          wr_ptr <= base_ptr + 1'b1;
          if( wr_last_i )
            begin
              full_o <= 1'b1;                           // line complete, held until flushed
              len_o  <= { 1'b0, base_ptr } + 1'b1;
            end
        end
      else
        if( flush_i )
          wr_ptr <= '0;
    end

endmodule

//--- source/window_buf.sv
`timescale 1ns/1ps

module window_buf
  import box_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  stream_word_t video_i,
  output logic         video_ready_o,
  output window_t      win_o,
  input  logic         win_ready_i
);

logic [LINE_BUFS - 1 : 0]   wr_sel;
logic [LINE_BUFS - 1 : 0]   wr_hit;
logic [LINE_BUFS - 1 : 0]   line_full;
logic [LINE_BUFS - 1 : 0]   line_flush;
logic [LINE_ADDR_W : 0]     line_len [LINE_BUFS];
px_t                        rd_px    [LINE_BUFS];
logic                       frame_start;
logic                       wr_accept;
logic                       lines_ready;
logic                       rd_idle;
logic                       rd_go;
logic [BUF_IDX_W - 1 : 0]   rd_pos;
logic                       rd_active;
logic                       iss_done;
logic [LINE_ADDR_W - 1 : 0] rd_col;
logic [LINE_ADDR_W - 1 : 0] rd_addr;
logic [LINE_ADDR_W : 0]     last_col;
logic                       d1_valid;
logic                       d1_last;
logic [LINE_ADDR_W - 1 : 0] d1_col;
logic                       advance;
logic                       pass_end;
logic                       win_load;
logic                       first_pend;
px_t [WIN - 1 : 0]          col_px;
px_t [WIN - 1 : 0][WIN - 1 : 0] win_px;
logic                       win_valid;
logic                       win_last;
logic                       win_user;

//////////////////////////////
// write side
//////////////////////////////

assign frame_start   = video_i.tvalid && video_i.tuser;
assign wr_hit        = frame_start ? LINE_BUFS'( 1 ) : wr_sel;
// a new frame waits until the previous one has been read out
assign video_ready_o = frame_start ? rd_idle : !( |( wr_sel & line_full ) );
assign wr_accept     = video_i.tvalid && video_ready_o;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    wr_sel <= LINE_BUFS'( 1 );
  else
    if( wr_accept )
      begin
        if( video_i.tlast )
          wr_sel <= { wr_hit[LINE_BUFS - 2 : 0], wr_hit[LINE_BUFS - 1] };
        else
          wr_sel <= wr_hit;
      end

for( genvar i = 0; i < LINE_BUFS; i++ )
  begin : g_line
    assign line_flush[i] = ( wr_accept && frame_start ) ||
                           ( pass_end && ( rd_pos == BUF_IDX_W'( i ) ) );

    line_buf line_buf_i (
      .clk_i     ( clk_i                 ),
      .rst_i     ( rst_i                 ),
      .wr_i      ( wr_accept && wr_hit[i] ),
      .wr_px_i   ( video_i.tdata         ),
      .wr_last_i ( video_i.tlast         ),
      .rd_addr_i ( rd_addr               ),
      .flush_i   ( line_flush[i]         ),
      .rd_px_o   ( rd_px[i]              ),
      .full_o    ( line_full[i]          ),
      .len_o     ( line_len[i]           )
    );
  end

//////////////////////////////
// read side
//////////////////////////////

always_comb
  begin
    lines_ready = 1'b1;
    for( int k = 0; k < WIN; k++ )
      begin
        lines_ready = lines_ready && line_full[rd_pos + BUF_IDX_W'( k )];
        col_px[k]   = rd_px[rd_pos + BUF_IDX_W'( k )];   // row 0 from the oldest line
      end
  end

assign rd_go    = !rd_active && lines_ready;
assign rd_idle  = !rd_active && !lines_ready;
assign last_col = line_len[rd_pos] - 1'b1;
assign advance  = win_ready_i || !win_valid;
assign rd_addr  = advance ? rd_col : d1_col;            // stalled, re-read the held column
assign pass_end = advance && d1_valid && d1_last;
assign win_load = advance && d1_valid && ( d1_col >= LINE_ADDR_W'( WIN - 1 ) );

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      rd_active <= 1'b0;
      iss_done  <= 1'b0;
      rd_col    <= '0;
      rd_pos    <= '0;
    end
  else
    if( wr_accept && frame_start )
      rd_pos <= '0;
    else
      if( rd_go )
        begin
          rd_active <= 1'b1;
          iss_done  <= 1'b0;
          rd_col    <= '0;
        end
      else
        if( pass_end )
          begin
            rd_active <= 1'b0;
            rd_pos    <= rd_pos + 1'b1;                 // oldest line is flushed now
          end
        else
          if( advance && rd_active && !iss_done )
            begin
              rd_col <= rd_col + 1'b1;
              if( { 1'b0, rd_col } == last_col )
                iss_done <= 1'b1;
            end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      d1_valid <= 1'b0;
      d1_last  <= 1'b0;
      d1_col   <= '0;
    end
  else
    if( advance )
      begin
        d1_valid <= rd_active && !iss_done;
        d1_last  <= ( { 1'b0, rd_col } == last_col );
        d1_col   <= rd_col;
      end

//////////////////////////////
// window register
//////////////////////////////

always_ff @( posedge clk_i )
  if( advance && d1_valid )
    for( int r = 0; r < WIN; r++ )
      begin
        for( int c = 0; c < WIN - 1; c++ )
          win_px[r][c] <= win_px[r][c + 1];
        win_px[r][WIN - 1] <= col_px[r];
      end

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    first_pend <= 1'b0;
  else
    if( wr_accept && frame_start )
      first_pend <= 1'b1;
    else
      if( win_load )
        first_pend <= 1'b0;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      win_valid <= 1'b0;
      win_last  <= 1'b0;
      win_user  <= 1'b0;
    end
  else
    if( advance )
      begin
        win_valid <= win_load;
        win_last  <= win_load && d1_last;
        win_user  <= win_load && first_pend;
      end

assign win_o = '{ px: win_px, tvalid: win_valid, tlast: win_last, tuser: win_user };

endmodule

//--- source/window_sum.sv
`timescale 1ns/1ps

module window_sum
  import box_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  window_t   win_i,
  output logic      win_ready_o,
  output sum_word_t sum_o,
  input  logic      sum_ready_i
);

logic [SUM_W - 1 : 0] row_sum [WIN];
logic [SUM_W - 1 : 0] part_q  [WIN];
logic [SUM_W - 1 : 0] total;
logic [SUM_W - 1 : 0] total_q;
logic                 s1_valid;
logic                 s1_last;
logic                 s1_user;
logic                 s2_valid;
logic                 s2_last;
logic                 s2_user;
logic                 adv1;
logic                 adv2;

assign adv2        = sum_ready_i || !s2_valid;
assign adv1        = adv2 || !s1_valid;
assign win_ready_o = adv1;

//////////////////////////////
// stage one, row sums
//////////////////////////////

always_comb
  for( int r = 0; r < WIN; r++ )
    begin
      row_sum[r] = '0;
      for( int c = 0; c < WIN; c++ )
        row_sum[r] = row_sum[r] + SUM_W'( win_i.px[r][c] );
    end

always_ff @( posedge clk_i )
  if( adv1 )
    part_q <= row_sum;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s1_user  <= 1'b0;
    end
  else
    if( adv1 )
      begin
        s1_valid <= win_i.tvalid;
        s1_last  <= win_i.tlast;
        s1_user  <= win_i.tuser;
      end

//////////////////////////////
// stage two, final sum
//////////////////////////////

always_comb
  begin
    total = '0;
    for( int r = 0; r < WIN; r++ )
      total = total + part_q[r];                        // 9 x 255 stays below 2**SUM_W
  end

always_ff @( posedge clk_i )
  if( adv2 )
    total_q <= total;

always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
      s2_user  <= 1'b0;
    end
  else
    if( adv2 )
      begin
        s2_valid <= s1_valid;
        s2_last  <= s1_last;
        s2_user  <= s1_user;
      end

assign sum_o = '{ tdata: total_q, tvalid: s2_valid, tlast: s2_last, tuser: s2_user };

endmodule

//--- source/box_filter_top.sv
`timescale 1ns/1ps

module box_filter_top
  import box_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_i,
  input  stream_word_t video_i,
  output logic         video_ready_o,
  output sum_word_t    sum_o,
  input  logic         sum_ready_i
);

window_t win;
logic    win_ready;

window_buf window_buf_i (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .video_i       ( video_i       ),
  .video_ready_o ( video_ready_o ),
  .win_o         ( win           ),
  .win_ready_i   ( win_ready     )
);

// two cycle adder tree behind the window builder
window_sum window_sum_i (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .win_i       ( win         ),
  .win_ready_o ( win_ready   ),
  .sum_o       ( sum_o       ),
  .sum_ready_i ( sum_ready_i )
);

endmodule

//--- dv/box_filter_sva.sv
`timescale 1ns/1ps

module box_filter_sva
  import box_pkg::*;
(
  input logic         clk_i,
  input logic         rst_i,
  input stream_word_t video_i,
  input logic         video_ready_i,
  input window_t      win_i,
  input logic         win_ready_i,
  input sum_word_t    sum_i,
  input logic         sum_ready_i
);

int unsigned fail_count = 0;
int unsigned starts;
int unsigned users;

// accepted frame starts against windows that carried tuser
always_ff @( posedge clk_i, posedge rst_i )
  if( rst_i )
    begin
      starts <= 0;
      users  <= 0;
    end
  else
    begin
      if( video_i.tvalid && video_i.tuser && video_ready_i )
        starts <= starts + 1;
      if( win_i.tvalid && win_i.tuser && win_ready_i )
        users <= users + 1;
    end

sum_held : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  sum_i.tvalid && !sum_ready_i |=> $stable( sum_i ) )
  else begin $error( "sum_o changed while stalled" ); fail_count++; end

reset_quiet : assert property ( @( posedge clk_i ) rst_i |-> !sum_i.tvalid )
  else begin $error( "sum_o.tvalid high in reset" ); fail_count++; end

user_once : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  win_i.tvalid && win_i.tuser |-> users < starts )
  else begin $error( "tuser on a window that does not start a frame" ); fail_count++; end

sum_known : assert property ( @( posedge clk_i ) disable iff ( rst_i )
  sum_i.tvalid |-> !$isunknown( sum_i ) )
  else begin $error( "sum_o carries unknown bits" ); fail_count++; end

endmodule

bind box_filter_top box_filter_sva sva_i (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .video_i       ( video_i       ),
  .video_ready_i ( video_ready_o ),
  .win_i         ( win           ),
  .win_ready_i   ( win_ready     ),
  .sum_i         ( sum_o         ),
  .sum_ready_i   ( sum_ready_i   )
);

//--- dv/box_filter_tb.sv
`timescale 1ns/1ps

module box_filter_tb
  import box_pkg::*;
();

localparam int TIMEOUT = 2000;                          // cycles allowed for any single wait

logic         clk_i;
logic         rst_i;
stream_word_t video_i;
logic         video_ready_o;
sum_word_t    sum_o;
logic         sum_ready_i;
logic         stall_on;
logic         saw_backpressure;
logic         ready_next;
int           seed = 83;
int           got_count;
int           frame_px [MAX_LINE_LEN][MAX_LINE_LEN];
int           exp_sum  [$];
logic [1 : 0] exp_flag [$];                             // { tlast, tuser } of each expected sum

box_filter_top box_filter_top_i (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .video_i       ( video_i       ),
  .video_ready_o ( video_ready_o ),
  .sum_o         ( sum_o         ),
  .sum_ready_i   ( sum_ready_i   )
);

initial
  begin
    clk_i = 1'b0;
    forever
      #5 clk_i = ~clk_i;
  end

// stalls are drawn on the edge and applied just after it
initial
  begin
    sum_ready_i = 1'b1;
    forever
      begin
        @( posedge clk_i );
        ready_next = stall_on ? ( ( $random( seed ) & 3 ) == 0 ) : 1'b1;
        #1 sum_ready_i = ready_next;
      end
  end

//////////////////////////////
// output monitor
//////////////////////////////

always @( posedge clk_i )
  if( !rst_i && sum_o.tvalid && sum_ready_i )
    begin
      assert( exp_sum.size() > 0 )
        else stop_with_failure( $sformatf( "[FAIL] %0t: unexpected sum %0d", $time,
                                           sum_o.tdata ) );
      assert( int'( sum_o.tdata ) == exp_sum[0] )
        else stop_with_failure( $sformatf( "[FAIL] %0t: sum %0d is %0d, expected %0d", $time,
                                           got_count, sum_o.tdata, exp_sum[0] ) );
      assert( { sum_o.tlast, sum_o.tuser } == exp_flag[0] )
        else stop_with_failure( $sformatf( "[FAIL] %0t: sum %0d has last/user %b, expected %b",
                                           $time, got_count, { sum_o.tlast, sum_o.tuser },
                                           exp_flag[0] ) );
      void'( exp_sum.pop_front() );
      void'( exp_flag.pop_front() );
      got_count++;
    end

task automatic stop_with_failure( input string line );
  $display( "%s", line );
  $display( "Simulation failed" );
  $fatal( 1 );
endtask

//////////////////////////////
// frames and reference model
//////////////////////////////

task automatic fill_frame( input int h, input int w, input int value, input logic randomize );
  for( int r = 0; r < h; r++ )
    for( int c = 0; c < w; c++ )
      if( randomize )
        frame_px[r][c] = ( ( r * w + c ) * 5 + ( $random( seed ) & 31 ) ) & 255;  // ramp plus noise
      else
        frame_px[r][c] = value;
endtask

// one sum per window that lies fully inside the frame, in raster order
task automatic expect_frame( input int h, input int w );
  int acc;
  for( int r = WIN - 1; r < h; r++ )
    for( int c = WIN - 1; c < w; c++ )
      begin
        acc = 0;
        for( int dr = 0; dr < WIN; dr++ )
          for( int dc = 0; dc < WIN; dc++ )
            acc += frame_px[r - dr][c - dc];
        exp_sum.push_back( acc );
        exp_flag.push_back( { c == w - 1, r == WIN - 1 && c == WIN - 1 } );
      end
endtask

task automatic drive_frame( input int h, input int w );
  int waits;
  for( int r = 0; r < h; r++ )
    for( int c = 0; c < w; c++ )
      begin
        video_i = '{ tdata: px_t'( frame_px[r][c] ), tvalid: 1'b1, tlast: c == w - 1,
                     tuser: r == 0 && c == 0 };
        waits   = 0;
        @( posedge clk_i );
        while( !video_ready_o )
          begin
            saw_backpressure = 1'b1;
            waits++;
            assert( waits < TIMEOUT ) else stop_with_failure( "timeout waiting for video_ready_o" );
            @( posedge clk_i );
          end
        #1;
      end
  video_i = '0;
endtask

task automatic wait_drained();
  int waits;
  waits = 0;
  while( exp_sum.size() > 0 )
    begin
      waits++;
      assert( waits < TIMEOUT ) else stop_with_failure( "timeout waiting for the expected sums" );
      @( posedge clk_i );
      #1;
    end
endtask

//////////////////////////////
// directed tests
//////////////////////////////

task automatic reset_state_check();
  assert( video_ready_o === 1'b1 )
    else stop_with_failure( $sformatf( "[FAIL] %0t: video_ready_o low after reset", $time ) );
  assert( sum_o.tvalid === 1'b0 )
    else stop_with_failure( $sformatf( "[FAIL] %0t: sum_o.tvalid high after reset", $time ) );
endtask

task automatic frame_check( input int h, input int w, input int value, input logic randomize );
  fill_frame( h, w, value, randomize );
  expect_frame( h, w );
  drive_frame( h, w );
  wait_drained();
endtask

// replays the last frame while the output is mostly stalled
task automatic stalled_repeat();
  stall_on         = 1'b1;
  saw_backpressure = 1'b0;
  expect_frame( 6, 8 );
  drive_frame( 6, 8 );
  wait_drained();
  stall_on = 1'b0;
  assert( saw_backpressure ) else stop_with_failure( "video_ready_o never dropped during stalls" );
endtask

task automatic width_change();
  fill_frame( 5, 16, 0, 1'b1 );
  expect_frame( 5, 16 );
  drive_frame( 5, 16 );
  fill_frame( 5, 4, 0, 1'b1 );                          // next frame follows at once
  expect_frame( 5, 4 );
  drive_frame( 5, 4 );
  wait_drained();
endtask

initial
  begin
    video_i          = '0;
    rst_i            = 1'b1;
    stall_on         = 1'b0;
    saw_backpressure = 1'b0;
    got_count        = 0;
    repeat( 10 ) @( posedge clk_i );
    #1 rst_i = 1'b0;
    @( posedge clk_i );
    #1;
    reset_state_check();
    frame_check( 5, 5, 10, 1'b0 );                      // nine sums of 90
    frame_check( 6, 8, 0, 1'b1 );
    stalled_repeat();
    width_change();
    frame_check( 5, 5, 255, 1'b0 );                     // full scale, 2295 each
    repeat( 20 ) @( posedge clk_i );                    // a stray sum would still hit the monitor
    if( box_filter_top_i.sva_i.fail_count == 0 )
      begin
        $display( "Simulation completed successfully" );
        $finish;
      end
    else
      stop_with_failure( "the bound assertions reported errors" );
  end

endmodule

//--- src.f
source/box_pkg.sv
source/line_buf.sv
source/window_buf.sv
source/window_sum.sv
source/box_filter_top.sv
dv/box_filter_sva.sv
dv/box_filter_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

out=$( { verilator --binary --timing --assert -Wno-fatal -f src.f --top-module box_filter_tb \
  && ./obj_dir/Vbox_filter_tb +verilator+error+limit+100 ; } 2>&1 )
echo "$out"

echo "$out" | grep -q "^Simulation completed successfully$" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }
